// File: common/trig_pkg.sv
package trig_pkg;

	//////////////////////////////////////////////////
	// Serial trigger frame
	//////////////////////////////////////////////////

	// Token width in bits
	localparam int TOKEN_W = 10;
	// Token bits plus one parity bit
	localparam int DATA_BITS = TOKEN_W + 1;
	// Counter wide enough for the data phase
	localparam int BIT_CNT_W = $clog2(DATA_BITS + 1);

	// FIFO record sequence width
	localparam int SEQ_W = 4;

	//////////////////////////////////////////////////
	// Front panel LEDs
	//////////////////////////////////////////////////

	localparam int NUM_LEDS = 4;
	localparam int LED_CNT_W = 5;
	// Cycles lit after the last trigger
	localparam logic [LED_CNT_W-1:0] LED_HOLD = LED_CNT_W'(16);

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	typedef logic [TOKEN_W-1:0] token_t;

	// Word toward the channel FPGAs
	typedef struct packed {
		logic [4:0] tag;
		logic       err;
		token_t     token;
	} tx_word_t;

	// Record toward the memory FIFO
	typedef struct packed {
		logic [SEQ_W-1:0] seq;
		logic             rsvd;
		logic             err;
		token_t           token;
	} tok_rec_t;

	// Frame receiver states
	typedef enum logic [1:0] {
		IDLE,
		DATA,
		STOP
	} rx_state_t;

	// Idle comma, sent with K set
	localparam tx_word_t COMMA_WORD = 16'h00BC;
	// Prefix of a data token word
	localparam logic [4:0] TOKEN_TAG = 5'b10000;

endpackage

// File: trig_rx/trig_rx_fsm.sv
`timescale 1ns/1ps

module trig_rx_fsm (
	input  logic CLK125,
	input  logic rst_n_i,
	// Serial trigger line, idles low
	input  logic ser_trig_i,
	// Even parity result from the shifter
	input  logic parity_ok_i,
	output logic shift_clr_o,
	output logic shift_en_o,
	// One-cycle token strobe and its status
	output logic tok_rdy_o,
	output logic tok_err_o
);

	//////////////////////////////////////////////////
	// State and counters
	//////////////////////////////////////////////////

	trig_pkg::rx_state_t state_q;
	// Counts the 11 data cycles
	logic [trig_pkg::BIT_CNT_W-1:0] bit_cnt_q;
	// Stop bit sampled, frame finished
	logic done_q;
	// Frame error, captured with the stop bit
	logic err_q;

	// Start bit seen in IDLE
	assign shift_clr_o = (state_q == trig_pkg::IDLE) && ser_trig_i;
	// Token and parity bits
	assign shift_en_o = (state_q == trig_pkg::DATA);

	//////////////////////////////////////////////////
	// Frame sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			state_q <= trig_pkg::IDLE;
			bit_cnt_q <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state_q)
				trig_pkg::IDLE: begin
					// Start bit is a 1
					if (ser_trig_i) begin
						state_q <= trig_pkg::DATA;
						bit_cnt_q <= '0;
					end
				end
				trig_pkg::DATA: begin
					bit_cnt_q <= bit_cnt_q + 1'b1;
					// Last data cycle is the parity bit
					if (bit_cnt_q == trig_pkg::BIT_CNT_W'(trig_pkg::DATA_BITS - 1)) begin
						state_q <= trig_pkg::STOP;
					end
				end
				trig_pkg::STOP: begin
					// Stop bit sampled here, free for a new start next edge
					done_q <= 1'b1;
					state_q <= trig_pkg::IDLE;
				end
				default: begin
					state_q <= trig_pkg::IDLE;
				end
			endcase
		end
	end

	// Bad parity or a stop bit of 1
	always_ff @(posedge CLK125) begin
		if (state_q == trig_pkg::STOP) begin
			err_q <= !parity_ok_i || ser_trig_i;
		end
	end

	//////////////////////////////////////////////////
	// Output strobes
	//////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			tok_rdy_o <= 1'b0;
			tok_err_o <= 1'b0;
		end else begin
			tok_rdy_o <= done_q;
			// Error only meaningful with the strobe
			tok_err_o <= done_q && err_q;
		end
	end

endmodule

// File: trig_rx/token_shift.sv
`timescale 1ns/1ps

module token_shift (
	input  logic CLK125,
	input  logic rst_n_i,
	input  logic ser_trig_i,
	// Start bit strobe
	input  logic shift_clr_i,
	// High through the data phase
	input  logic shift_en_i,
	output trig_pkg::token_t token_o,
	output logic parity_ok_o
);

	// Token bits MSB first, then parity in bit 0
	logic [trig_pkg::DATA_BITS-1:0] shift_q;
	// Running XOR over token and parity
	logic par_q;

	//////////////////////////////////////////////////
	// Capture
	//////////////////////////////////////////////////

	// All 11 bits are overwritten by each frame
	always_ff @(posedge CLK125) begin
		if (shift_en_i) begin
			shift_q <= {shift_q[trig_pkg::DATA_BITS-2:0], ser_trig_i};
		end
	end

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			par_q <= 1'b0;
		end else if (shift_clr_i) begin
			// New frame, restart the parity
			par_q <= 1'b0;
		end else if (shift_en_i) begin
			par_q <= par_q ^ ser_trig_i;
		end
	end

	// Held until the next frame shifts in
	assign token_o = shift_q[trig_pkg::DATA_BITS-1:1];
	// Even number of ones
	assign parity_ok_o = !par_q;

endmodule

// File: rtl/token_dispatch.sv
`timescale 1ns/1ps

module token_dispatch (
	input  logic CLK125,
	input  logic rst_n_i,
	// Token strobe and status from the receiver
	input  logic tok_rdy_i,
	input  logic tok_err_i,
	input  trig_pkg::token_t token_i,
	// Record gating
	input  logic enable_i,
	input  logic inhibit_i,
	// Word stream toward the channel FPGAs
	output trig_pkg::tx_word_t tx_word_o,
	output logic tx_kchar_o,
	// Memory FIFO record
	output trig_pkg::tok_rec_t tok_dat_o,
	output logic tok_vld_o
);

	// Records emitted so far, wraps
	logic [trig_pkg::SEQ_W-1:0] seq_q;
	// Token goes to the FIFO
	logic rec_accept;

	assign rec_accept = tok_rdy_i && enable_i && !inhibit_i;

	//////////////////////////////////////////////////
	// Outgoing word stream
	//////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			tx_word_o <= trig_pkg::COMMA_WORD;
			tx_kchar_o <= 1'b1;
		end else if (tok_rdy_i) begin
			// Data word for one cycle, K clear
			tx_word_o.tag <= trig_pkg::TOKEN_TAG;
			tx_word_o.err <= tok_err_i;
			tx_word_o.token <= token_i;
			tx_kchar_o <= 1'b0;
		end else begin
			// Comma otherwise
			tx_word_o <= trig_pkg::COMMA_WORD;
			tx_kchar_o <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// FIFO record
	//////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			tok_vld_o <= 1'b0;
			seq_q <= '0;
		end else begin
			tok_vld_o <= rec_accept;
			// Advance only on emitted records
			if (rec_accept) begin
				seq_q <= seq_q + 1'b1;
			end
		end
	end

	// Record payload, stamped with the current count
	always_ff @(posedge CLK125) begin
		if (rec_accept) begin
			tok_dat_o.seq <= seq_q;
			tok_dat_o.rsvd <= 1'b0;
			tok_dat_o.err <= tok_err_i;
			tok_dat_o.token <= token_i;
		end
	end

endmodule

// File: rtl/led_stretch.sv
`timescale 1ns/1ps

module led_stretch (
	input  logic CLK125,
	input  logic rst_n_i,
	// Pulse or level, retriggers the hold
	input  logic trig_i,
	output logic led_o
);

	// Cycles left to stay lit
	logic [trig_pkg::LED_CNT_W-1:0] hold_q;

	//////////////////////////////////////////////////
	// Hold timer
	//////////////////////////////////////////////////

	always_ff @(posedge CLK125) begin
		if (!rst_n_i) begin
			hold_q <= '0;
		end else if (trig_i) begin
			// Reload on every trigger cycle
			hold_q <= trig_pkg::LED_HOLD;
		end else if (hold_q != '0) begin
			hold_q <= hold_q - 1'b1;
		end
	end

	// Lit while time is left
	assign led_o = (hold_q != '0);

endmodule

// File: rtl/trig_token_top.sv
`timescale 1ns/1ps

module trig_token_top (
	input  logic CLK125,
	input  logic rst_n_i,
	// Serial master trigger from the inter-FPGA bus
	input  logic ser_trig_i,
	// FIFO record enable
	input  logic enable_i,
	// Global inhibit
	input  logic inhibit_i,
	// Bus access strobe for the activity LED
	input  logic bus_access_i,
	// Token stream toward the channel FPGAs
	output trig_pkg::tx_word_t tx_word_o,
	output logic tx_kchar_o,
	// Token record toward the memory FIFO
	output trig_pkg::tok_rec_t tok_dat_o,
	output logic tok_vld_o,
	// Front panel LEDs
	output logic [trig_pkg::NUM_LEDS-1:0] led_o
);

	//////////////////////////////////////////////////
	// Internal nets
	//////////////////////////////////////////////////

	// FSM to shifter
	logic shift_clr;
	logic shift_en;
	// Shifter to FSM and dispatch
	logic parity_ok;
	trig_pkg::token_t token;
	// Token strobe and status
	logic tok_rdy;
	logic tok_err;

	// LED triggers
	// 0 yellow, token receive error
	// 1 green, bus access
	// 2 green, master trigger received
	// 3 green, no inhibit
	wire [trig_pkg::NUM_LEDS-1:0] led_trig = {
		!inhibit_i,
		tok_rdy,
		bus_access_i,
		tok_rdy && tok_err
	};

	//////////////////////////////////////////////////
	// Serial trigger receiver
	//////////////////////////////////////////////////

	trig_rx_fsm u_rx_fsm (
		.CLK125      (CLK125),
		.rst_n_i     (rst_n_i),
		.ser_trig_i  (ser_trig_i),
		.parity_ok_i (parity_ok),
		.shift_clr_o (shift_clr),
		.shift_en_o  (shift_en),
		.tok_rdy_o   (tok_rdy),
		.tok_err_o   (tok_err)
	);

	// Token and parity capture
	token_shift u_shift (
		.CLK125      (CLK125),
		.rst_n_i     (rst_n_i),
		.ser_trig_i  (ser_trig_i),
		.shift_clr_i (shift_clr),
		.shift_en_i  (shift_en),
		.token_o     (token),
		.parity_ok_o (parity_ok)
	);

	//////////////////////////////////////////////////
	// Token word and FIFO record
	//////////////////////////////////////////////////

	token_dispatch u_dispatch (
		.CLK125     (CLK125),
		.rst_n_i    (rst_n_i),
		.tok_rdy_i  (tok_rdy),
		.tok_err_i  (tok_err),
		.token_i    (token),
		.enable_i   (enable_i),
		.inhibit_i  (inhibit_i),
		.tx_word_o  (tx_word_o),
		.tx_kchar_o (tx_kchar_o),
		.tok_dat_o  (tok_dat_o),
		.tok_vld_o  (tok_vld_o)
	);

	//////////////////////////////////////////////////
	// LED stretchers
	//////////////////////////////////////////////////

	// One hold timer per LED
	genvar i;
	generate
		for (i = 0; i < trig_pkg::NUM_LEDS; i = i + 1) begin : g_led
			led_stretch u_led (
				.CLK125  (CLK125),
				.rst_n_i (rst_n_i),
				.trig_i  (led_trig[i]),
				.led_o   (led_o[i])
			);
		end
	endgenerate

endmodule

// File: bench/tb_trig_token.sv
`timescale 1ns/1ps

module tb_trig_token;

	//////////////////////////////////////////////////
	// DUT, clock and run state
	//////////////////////////////////////////////////

	// Expectation tables indexed by clock edge
	localparam int DEPTH = 2048;
	// Reset, four directed tests and 20 frames take about 500 cycles
	localparam int MAX_CYC = 4 * 500;

	logic CLK125 = 1'b0;
	logic rst_n_i;
	logic ser_trig_i;
	logic enable_i;
	logic inhibit_i;
	logic bus_access_i;
	trig_pkg::tx_word_t tx_word_o;
	logic tx_kchar_o;
	trig_pkg::tok_rec_t tok_dat_o;
	logic tok_vld_o;
	logic [trig_pkg::NUM_LEDS-1:0] led_o;

	int cyc = 0;
	int err_cnt = 0;
	int tests_run = 0;
	int tests_failed = 0;
	string cur_test = "reset";
	integer seed = 32'h677760f1;

	// Token as dispatch samples it, N+14 of its frame
	bit exp_tok_at [0:DEPTH-1];
	bit exp_err [0:DEPTH-1];
	trig_pkg::token_t exp_tok [0:DEPTH-1];
	// Records emitted so far
	logic [trig_pkg::SEQ_W-1:0] seq_model = '0;
	// Last edge with each LED trigger high
	int led_last [0:trig_pkg::NUM_LEDS-1];
	// Inputs as sampled by the DUT at the last edge
	logic smp_rst = 1'b0;
	logic smp_en = 1'b0;
	logic smp_inh = 1'b0;
	logic smp_ba = 1'b0;

	trig_token_top dut_i (.*);

	always #4 CLK125 = ~CLK125;

	// Edge index, code woken on an edge still sees that edge's number
	always @(posedge CLK125) cyc <= cyc + 1;

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_word(input trig_pkg::tx_word_t exp_w, input logic exp_k);
		if (tx_word_o !== exp_w || tx_kchar_o !== exp_k) begin
			err_cnt++;
			$display("[ERROR] %s: word expected %h k=%b, actual %h k=%b",
				cur_test, exp_w, exp_k, tx_word_o, tx_kchar_o);
		end
	endtask

	task automatic check_rec(input trig_pkg::tok_rec_t exp_r);
		if (tok_dat_o !== exp_r) begin
			err_cnt++;
			$display("[ERROR] %s: record expected %h, actual %h", cur_test, exp_r, tok_dat_o);
		end
	endtask

	task automatic check_leds(input logic [trig_pkg::NUM_LEDS-1:0] exp_led);
		if (led_o !== exp_led) begin
			err_cnt++;
			$display("[ERROR] %s: leds expected %b, actual %b", cur_test, exp_led, led_o);
		end
	endtask

	task automatic report_fault(input string what);
		err_cnt++;
		$display("%s: %s", cur_test, what);
	endtask

	//////////////////////////////////////////////////
	// Cycle monitor
	//////////////////////////////////////////////////

	// Runs on the falling edge, outputs of edge e are settled
	always @(negedge CLK125) begin : monitor
		int e;
		int i;
		logic [trig_pkg::NUM_LEDS-1:0] trig;
		logic [trig_pkg::NUM_LEDS-1:0] led_exp;
		trig_pkg::tx_word_t w;
		trig_pkg::tok_rec_t r;
		e = cyc - 1;
		if (!smp_rst) begin
			check_word(trig_pkg::COMMA_WORD, 1'b1);
			check_leds('0);
			if (tok_vld_o !== 1'b0)
				report_fault("tok_vld_o is high while in reset");
		end else begin
			// LED triggers as seen at edge e
			trig[0] = exp_tok_at[e] && exp_err[e];
			trig[1] = smp_ba;
			trig[2] = exp_tok_at[e];
			trig[3] = !smp_inh;
			for (i = 0; i < trig_pkg::NUM_LEDS; i++) begin
				if (trig[i])
					led_last[i] = e;
				// Lit for LED_HOLD edges counted from the last trigger
				led_exp[i] = (e - led_last[i]) < int'(trig_pkg::LED_HOLD);
			end
			check_leds(led_exp);
			if (exp_tok_at[e]) begin
				w.tag = trig_pkg::TOKEN_TAG;
				w.err = exp_err[e];
				w.token = exp_tok[e];
				check_word(w, 1'b0);
			end else begin
				check_word(trig_pkg::COMMA_WORD, 1'b1);
			end
			// Record only with enable high and inhibit low
			if (exp_tok_at[e] && smp_en && !smp_inh) begin
				r.seq = seq_model;
				r.rsvd = 1'b0;
				r.err = exp_err[e];
				r.token = exp_tok[e];
				seq_model = seq_model + 1'b1;
				if (tok_vld_o !== 1'b1)
					report_fault("tok_vld_o did not pulse for an accepted token");
				else
					check_rec(r);
			end else if (tok_vld_o !== 1'b0) begin
				report_fault("tok_vld_o pulsed with no accepted token");
			end
		end
		smp_rst = rst_n_i;
		smp_en = enable_i;
		smp_inh = inhibit_i;
		smp_ba = bus_access_i;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// Start, ten token bits MSB first, even parity, stop
	task automatic send_frame(input trig_pkg::token_t tok, input logic bad_par,
			input logic bad_stop, output int n_edge);
		logic [12:0] frame;
		logic par;
		int k;
		par = (^tok) ^ bad_par;
		frame = {1'b1, tok, par, bad_stop};
		for (k = 12; k >= 0; k--) begin
			@(posedge CLK125);
			// Start bit sampled on the following edge
			if (k == 12)
				n_edge = cyc + 1;
			ser_trig_i <= frame[k];
		end
		exp_tok_at[n_edge + 14] = 1'b1;
		exp_tok[n_edge + 14] = tok;
		exp_err[n_edge + 14] = bad_par || bad_stop;
	endtask

	// Line back to idle, then wait for an edge
	task automatic idle_until(input int target);
		@(posedge CLK125);
		ser_trig_i <= 1'b0;
		while (cyc < target)
			@(posedge CLK125);
	endtask

	task automatic finish_test(input int errs_before);
		tests_run++;
		if (err_cnt == errs_before) begin
			$display("[TEST] %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("[TEST] %s: %0d errors", cur_test, err_cnt - errs_before);
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic test_reset;
		int errs;
		cur_test = "reset";
		errs = err_cnt;
		repeat (5) @(posedge CLK125);
		rst_n_i <= 1'b1;
		// LED 3 comes up right after release
		idle_until(cyc + 4);
		finish_test(errs);
	endtask

	task automatic test_idle_good;
		int errs;
		int n;
		cur_test = "idle_good";
		errs = err_cnt;
		@(posedge CLK125);
		enable_i <= 1'b1;
		idle_until(cyc + 12);
		send_frame(10'h2A5, 1'b0, 1'b0, n);
		idle_until(n + 16);
		finish_test(errs);
	endtask

	task automatic test_frame_errors;
		int errs;
		int n;
		cur_test = "frame_errors";
		errs = err_cnt;
		send_frame(10'h0F3, 1'b1, 1'b0, n);
		// Long enough for LED 0 to go dark
		idle_until(n + 32);
		send_frame(10'h30C, 1'b0, 1'b1, n);
		idle_until(n + 32);
		finish_test(errs);
	endtask

	task automatic test_gating;
		int errs;
		int n;
		cur_test = "gating";
		errs = err_cnt;
		@(posedge CLK125);
		enable_i <= 1'b0;
		send_frame(10'h155, 1'b0, 1'b0, n);
		idle_until(n + 16);
		enable_i <= 1'b1;
		inhibit_i <= 1'b1;
		send_frame(10'h2AA, 1'b0, 1'b0, n);
		idle_until(n + 16);
		inhibit_i <= 1'b0;
		// Next accepted record takes the next sequence
		send_frame(10'h3C1, 1'b0, 1'b0, n);
		idle_until(n + 32);
		finish_test(errs);
	endtask

	task automatic test_led_stretch;
		int errs;
		int n;
		cur_test = "led_stretch";
		errs = err_cnt;
		@(posedge CLK125);
		bus_access_i <= 1'b1;
		@(posedge CLK125);
		bus_access_i <= 1'b0;
		idle_until(cyc + 20);
		send_frame(10'h1E7, 1'b0, 1'b0, n);
		idle_until(n + 32);
		inhibit_i <= 1'b1;
		// LED 3 holds for LED_HOLD cycles, then drops
		idle_until(cyc + 20);
		inhibit_i <= 1'b0;
		idle_until(cyc + 4);
		finish_test(errs);
	endtask

	task automatic test_back_to_back;
		int errs;
		int n;
		int k;
		logic [31:0] rnd;
		cur_test = "back_to_back";
		errs = err_cnt;
		// Each start lands on N+13 of the previous frame
		for (k = 0; k < 20; k++) begin
			rnd = $random(seed);
			send_frame(rnd[trig_pkg::TOKEN_W-1:0], 1'b0, 1'b0, n);
		end
		idle_until(n + 16);
		finish_test(errs);
	endtask

	initial begin : main
		int i;
		rst_n_i = 1'b0;
		ser_trig_i = 1'b0;
		enable_i = 1'b0;
		inhibit_i = 1'b0;
		bus_access_i = 1'b0;
		for (i = 0; i < trig_pkg::NUM_LEDS; i++)
			led_last[i] = -100;
		test_reset();
		test_idle_good();
		test_frame_errors();
		test_gating();
		test_led_stretch();
		test_back_to_back();
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Run limit
	initial begin : watchdog
		while (cyc < MAX_CYC)
			@(posedge CLK125);
		$display("Timeout: run did not finish within %0d cycles", MAX_CYC);
		$display("Verification failed");
		$finish;
	end

endmodule

// File: filelist.f
common/trig_pkg.sv
trig_rx/trig_rx_fsm.sv
trig_rx/token_shift.sv
rtl/token_dispatch.sv
rtl/led_stretch.sv
rtl/trig_token_top.sv
bench/tb_trig_token.sv
